// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int MBUS_DATA_W = 64;

  // address map
  localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'h0200_bff8;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = 32'h0200_bffc;
  localparam logic [ADDR_W-1:0] SERIAL_ADDR   = 32'h1000_0000;

  typedef logic [2:0] size_t;

  // bytes per beat as log2
  localparam size_t SIZE_BYTE = 3'd0;
  localparam size_t SIZE_HALF = 3'd1;
  localparam size_t SIZE_WORD = 3'd2;

  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W/8-1:0] strb;
  } core_rd_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
  } core_wr_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    size_t             size;
  } mbus_ar_t;

  typedef struct packed {
    logic [MBUS_DATA_W-1:0] data;
    logic [1:0]             resp;
  } mbus_r_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    size_t             size;
  } mbus_aw_t;

  typedef struct packed {
    logic [MBUS_DATA_W-1:0]   data;
    logic [MBUS_DATA_W/8-1:0] strb;
    logic                     last;
  } mbus_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } mbus_b_t;

  typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, WR_ADDR, WR_RESP, LOCAL} grant_t;

endpackage

`default_nettype wire

// ==== bus_arbiter/lane_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_align (
  input  wire bus_pkg::core_rd_req_t       rd_req_i,
  input  wire bus_pkg::core_wr_req_t       wr_req_i,
  input  wire bus_pkg::mbus_r_t            r_i,
  input  wire logic [bus_pkg::DATA_W-1:0]  local_rdata_i,
  input  wire logic                        local_sel_i,
  output bus_pkg::mbus_ar_t                ar_o,
  output bus_pkg::mbus_aw_t                aw_o,
  output bus_pkg::mbus_w_t                 w_o,
  output logic [bus_pkg::DATA_W-1:0]       rdata_o
);
  import bus_pkg::*;

  logic [DATA_W-1:0]   rd_half;
  logic [DATA_W-1:0]   rd_shift;
  logic [DATA_W-1:0]   rd_mask;
  logic [DATA_W-1:0]   wr_shift;
  logic [DATA_W/8-1:0] wr_strb;

  function automatic size_t strb_to_size(input logic [DATA_W/8-1:0] strb);
    case (strb)
      4'h1:    strb_to_size = SIZE_BYTE;
      4'h3:    strb_to_size = SIZE_HALF;
      default: strb_to_size = SIZE_WORD;
    endcase
  endfunction

  // addr[2] picks the word inside the 64-bit beat
  assign rd_half  = rd_req_i.addr[2] ? r_i.data[63:32] : r_i.data[31:0];
  assign rd_shift = rd_half >> {rd_req_i.addr[1:0], 3'b000};

  // zero extension, lanes above the access size are cleared
  always_comb
  begin
    for (int i = 0; i < DATA_W/8; i++)
    begin
      rd_mask[8*i +: 8] = {8{rd_req_i.strb[i]}};
    end
  end

  assign rdata_o = local_sel_i ? local_rdata_i : (rd_shift & rd_mask);

  assign wr_shift = wr_req_i.data << {wr_req_i.addr[1:0], 3'b000};
  assign wr_strb  = wr_req_i.strb << wr_req_i.addr[1:0];

  always_comb
  begin
    ar_o.addr = rd_req_i.addr;
    ar_o.size = strb_to_size(rd_req_i.strb);
    aw_o.addr = wr_req_i.addr;
    aw_o.size = strb_to_size(wr_req_i.strb);
    // data goes on both halves, the strobe picks the live one
    w_o.data  = {wr_shift, wr_shift};
    w_o.strb  = wr_req_i.addr[2] ? {wr_strb, 4'b0000} : {4'b0000, wr_strb};
    w_o.last  = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bus_arbiter/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  ifu_valid_i,
  input  wire bus_pkg::core_rd_req_t ifu_req_i,
  input  wire logic                  lsu_rd_valid_i,
  input  wire bus_pkg::core_rd_req_t lsu_rd_req_i,
  input  wire logic                  lsu_wr_valid_i,
  input  wire bus_pkg::core_wr_req_t lsu_wr_req_i,
  output logic                       ifu_done_o,
  output logic                       lsu_rd_done_o,
  output logic                       lsu_wr_done_o,
  output bus_pkg::core_rd_req_t      sel_rd_o,
  output bus_pkg::core_wr_req_t      sel_wr_o,
  output logic                       ar_valid_o,
  input  wire logic                  ar_ready_i,
  input  wire logic                  r_valid_i,
  output logic                       r_ready_o,
  input  wire bus_pkg::mbus_r_t      r_i,
  output bus_pkg::mbus_r_t           r_hold_o,
  output logic                       aw_valid_o,
  input  wire logic                  aw_ready_i,
  output logic                       w_valid_o,
  input  wire logic                  w_ready_i,
  input  wire logic                  b_valid_i,
  output logic                       b_ready_o,
  output logic                       clint_rd_o,
  output logic                       serial_wr_o,
  output logic                       local_sel_o
);
  import bus_pkg::*;

  grant_t state;
  logic   is_wr_q;
  logic   is_ifu_q;
  logic   local_q;
  logic   aw_done_q;
  logic   w_done_q;
  logic   wr_take;
  logic   rd_take;
  logic   ifu_take;
  logic   wr_local;
  logic   wr_chan_done;
  logic   finish;

  function automatic logic is_clint(input logic [ADDR_W-1:0] addr);
    is_clint = (addr == MTIME_LO_ADDR) || (addr == MTIME_HI_ADDR);
  endfunction

  // a requester still holds valid in its done cycle, so mask it there
  assign wr_take  = lsu_wr_valid_i && !lsu_wr_done_o;
  assign rd_take  = lsu_rd_valid_i && !lsu_rd_done_o;
  assign ifu_take = ifu_valid_i && !ifu_done_o;
  assign wr_local = is_clint(lsu_wr_req_i.addr) || (lsu_wr_req_i.addr == SERIAL_ADDR);

  // aw and w may be accepted in different cycles
  assign wr_chan_done = (aw_done_q || aw_ready_i) && (w_done_q || w_ready_i);

  assign finish = (state == LOCAL) || (state == RD_DATA && r_valid_i) ||
                  (state == WR_RESP && b_valid_i);

  assign ar_valid_o  = (state == RD_ADDR);
  assign r_ready_o   = (state == RD_DATA);
  assign aw_valid_o  = (state == WR_ADDR) && !aw_done_q;
  assign w_valid_o   = (state == WR_ADDR) && !w_done_q;
  assign b_ready_o   = (state == WR_RESP);
  assign clint_rd_o  = (state == LOCAL) && !is_wr_q;
  assign serial_wr_o = (state == LOCAL) && is_wr_q && (sel_wr_o.addr == SERIAL_ADDR);
  assign local_sel_o = local_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state         <= IDLE;
      is_wr_q       <= 1'b0;
      is_ifu_q      <= 1'b0;
      local_q       <= 1'b0;
      aw_done_q     <= 1'b0;
      w_done_q      <= 1'b0;
      ifu_done_o    <= 1'b0;
      lsu_rd_done_o <= 1'b0;
      lsu_wr_done_o <= 1'b0;
    end
    else
    begin
      ifu_done_o    <= finish && !is_wr_q && is_ifu_q;
      lsu_rd_done_o <= finish && !is_wr_q && !is_ifu_q;
      lsu_wr_done_o <= finish && is_wr_q;
      case (state)
        IDLE:
        begin
          // store wins, then load, then fetch
          if (wr_take)
          begin
            is_wr_q  <= 1'b1;
            is_ifu_q <= 1'b0;
            local_q  <= wr_local;
            state    <= wr_local ? LOCAL : WR_ADDR;
          end
          else if (rd_take)
          begin
            is_wr_q  <= 1'b0;
            is_ifu_q <= 1'b0;
            local_q  <= is_clint(lsu_rd_req_i.addr);
            state    <= is_clint(lsu_rd_req_i.addr) ? LOCAL : RD_ADDR;
          end
          else if (ifu_take)
          begin
            is_wr_q  <= 1'b0;
            is_ifu_q <= 1'b1;
            local_q  <= is_clint(ifu_req_i.addr);
            state    <= is_clint(ifu_req_i.addr) ? LOCAL : RD_ADDR;
          end
        end
        RD_ADDR:
        begin
          if (ar_ready_i)
          begin
            state <= RD_DATA;
          end
        end
        RD_DATA:
        begin
          if (r_valid_i)
          begin
            state <= IDLE;
          end
        end
        WR_ADDR:
        begin
          if (wr_chan_done)
          begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            state     <= WR_RESP;
          end
          else
          begin
            aw_done_q <= aw_done_q || aw_ready_i;
            w_done_q  <= w_done_q || w_ready_i;
          end
        end
        WR_RESP:
        begin
          if (b_valid_i)
          begin
            state <= IDLE;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // winning request and read beat, held through the done cycle
  always_ff @(posedge clk)
  begin
    if (state == IDLE)
    begin
      if (wr_take)
      begin
        sel_wr_o <= lsu_wr_req_i;
      end
      else if (rd_take)
      begin
        sel_rd_o <= lsu_rd_req_i;
      end
      else if (ifu_take)
      begin
        sel_rd_o <= ifu_req_i;
      end
    end
    if (r_valid_i && r_ready_o)
    begin
      r_hold_o <= r_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/clint.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  rd_i,
  input  wire logic                  hi_sel_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o
);
  import bus_pkg::*;

  logic [2*DATA_W-1:0] mtime;

  // free running cycle counter
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime <= '0;
    end
    else
    begin
      mtime <= mtime + 1'b1;
    end
  end

  // sampled word is returned in the done cycle
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      rdata_o <= hi_sel_i ? mtime[2*DATA_W-1:DATA_W] : mtime[DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== source/serial_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_port (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       wr_i,
  input  wire logic [bus_pkg::DATA_W-1:0] wdata_i,
  output logic [7:0]                      char_o,
  output logic                            char_valid_o
);

  // one character per store, strobe lines up with the store done
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      char_valid_o <= 1'b0;
    end
    else
    begin
      char_valid_o <= wr_i;
    end
  end

  // port sits at a word aligned address, so the char is the low byte
  always_ff @(posedge clk)
  begin
    if (wr_i)
    begin
      char_o <= wdata_i[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== source/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  ifu_valid_i,
  input  wire bus_pkg::core_rd_req_t ifu_req_i,
  input  wire logic                  lsu_rd_valid_i,
  input  wire bus_pkg::core_rd_req_t lsu_rd_req_i,
  input  wire logic                  lsu_wr_valid_i,
  input  wire bus_pkg::core_wr_req_t lsu_wr_req_i,
  output logic                       ifu_done_o,
  output logic                       lsu_rd_done_o,
  output logic                       lsu_wr_done_o,
  output logic [bus_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic [bus_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic                       ar_valid_o,
  input  wire logic                  ar_ready_i,
  output bus_pkg::mbus_ar_t          ar_o,
  input  wire logic                  r_valid_i,
  output logic                       r_ready_o,
  input  wire bus_pkg::mbus_r_t      r_i,
  output logic                       aw_valid_o,
  input  wire logic                  aw_ready_i,
  output bus_pkg::mbus_aw_t          aw_o,
  output logic                       w_valid_o,
  input  wire logic                  w_ready_i,
  output bus_pkg::mbus_w_t           w_o,
  input  wire logic                  b_valid_i,
  output logic                       b_ready_o,
  // response code of the b channel is not inspected
  input  wire bus_pkg::mbus_b_t      b_i,
  output logic [7:0]                 char_o,
  output logic                       char_valid_o
);
  import bus_pkg::*;

  core_rd_req_t      sel_rd;
  core_wr_req_t      sel_wr;
  mbus_r_t           r_hold;
  logic              clint_rd;
  logic              serial_wr;
  logic              local_sel;
  logic [DATA_W-1:0] clint_rdata;
  logic [DATA_W-1:0] rdata;

  bus_arbiter u_arbiter (
    .*,
    .sel_rd_o    (sel_rd),
    .sel_wr_o    (sel_wr),
    .r_hold_o    (r_hold),
    .clint_rd_o  (clint_rd),
    .serial_wr_o (serial_wr),
    .local_sel_o (local_sel)
  );

  lane_align u_lane_align (
    .rd_req_i      (sel_rd),
    .wr_req_i      (sel_wr),
    .r_i           (r_hold),
    .local_rdata_i (clint_rdata),
    .local_sel_i   (local_sel),
    .ar_o          (ar_o),
    .aw_o          (aw_o),
    .w_o           (w_o),
    .rdata_o       (rdata)
  );

  clint u_clint (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (clint_rd),
    .hi_sel_i (sel_rd.addr[2]),
    .rdata_o  (clint_rdata)
  );

  serial_port u_serial (
    .clk          (clk),
    .rst          (rst),
    .wr_i         (serial_wr),
    .wdata_i      (sel_wr.data),
    .char_o       (char_o),
    .char_valid_o (char_valid_o)
  );

  // one aligner serves both readers, the done pulses tell them apart
  assign ifu_rdata_o = rdata;
  assign lsu_rdata_o = rdata;

endmodule

`default_nettype wire

// ==== dv/axi_mem_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_responder (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic [1:0]        delay_i,
  input  wire logic              ar_valid_i,
  output logic                   ar_ready_o,
  input  wire bus_pkg::mbus_ar_t ar_i,
  output logic                   r_valid_o,
  input  wire logic              r_ready_i,
  output bus_pkg::mbus_r_t       r_o,
  input  wire logic              aw_valid_i,
  output logic                   aw_ready_o,
  input  wire bus_pkg::mbus_aw_t aw_i,
  input  wire logic              w_valid_i,
  output logic                   w_ready_o,
  input  wire bus_pkg::mbus_w_t  w_i,
  output logic                   b_valid_o,
  input  wire logic              b_ready_i,
  output bus_pkg::mbus_b_t       b_o,
  output bus_pkg::mbus_ar_t      ar_seen_o,
  output bus_pkg::mbus_aw_t      aw_seen_o,
  output bus_pkg::mbus_w_t       w_seen_o,
  output int unsigned            w_count_o,
  output int unsigned            hs_count_o
);
  import bus_pkg::*;

  // 4 KiB, indexed by the low address bits
  logic [7:0]  mem [0:4095];
  int unsigned rd_hs;
  int unsigned wr_hs;

  assign hs_count_o = rd_hs + wr_hs;

  initial
  begin : read_side
    logic [11:0] base;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    ar_seen_o  = '0;
    rd_hs      = 0;
    forever
    begin
      @(posedge clk);
      if (!rst && ar_valid_i)
      begin
        repeat (delay_i) @(posedge clk);
        #1;
        ar_ready_o = 1'b1;
        @(posedge clk);
        base      = {ar_i.addr[11:3], 3'b000};
        ar_seen_o = ar_i;
        rd_hs     = rd_hs + 1;
        #1;
        ar_ready_o = 1'b0;
        repeat (delay_i) @(posedge clk);
        #1;
        // whole 64-bit beat, lane choice is up to the master
        for (int i = 0; i < 8; i++)
        begin
          r_o.data[8*i +: 8] = mem[base + i];
        end
        r_o.resp  = 2'b00;
        r_valid_o = 1'b1;
        @(posedge clk);
        while (!r_ready_i)
        begin
          @(posedge clk);
        end
        #1;
        r_valid_o = 1'b0;
      end
    end
  end

  initial
  begin : write_side
    logic [11:0] base;
    mbus_w_t     beat;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
    b_o        = '0;
    aw_seen_o  = '0;
    w_seen_o   = '0;
    w_count_o  = 0;
    wr_hs      = 0;
    forever
    begin
      @(posedge clk);
      if (!rst && aw_valid_i)
      begin
        repeat (delay_i) @(posedge clk);
        #1;
        aw_ready_o = 1'b1;
        @(posedge clk);
        base      = {aw_i.addr[11:3], 3'b000};
        aw_seen_o = aw_i;
        #1;
        aw_ready_o = 1'b0;
        // w accepted later than aw, so the master tracks them apart
        repeat (delay_i) @(posedge clk);
        #1;
        w_ready_o = 1'b1;
        @(posedge clk);
        beat = w_i;
        #1;
        w_ready_o = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
          if (beat.strb[i])
          begin
            mem[base + i] = beat.data[8*i +: 8];
          end
        end
        w_seen_o  = beat;
        w_count_o = w_count_o + 1;
        wr_hs     = wr_hs + 2;
        repeat (delay_i) @(posedge clk);
        #1;
        b_valid_o = 1'b1;
        @(posedge clk);
        while (!b_ready_i)
        begin
          @(posedge clk);
        end
        #1;
        b_valid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
  import bus_pkg::*;

  localparam int N_FETCH  = 40;
  localparam int N_LOAD   = 60;
  localparam int N_RACE   = 10;
  localparam int N_STORE  = 40;
  localparam int N_SERIAL = 4;
  localparam int N_OPS    = N_FETCH + 8 + N_LOAD + 2 * N_RACE + 3 * N_STORE + 3 + N_SERIAL;
  localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;

  logic              clk;
  logic              rst;
  logic              ifu_valid;
  core_rd_req_t      ifu_req;
  logic              lsu_rd_valid;
  core_rd_req_t      lsu_rd_req;
  logic              lsu_wr_valid;
  core_wr_req_t      lsu_wr_req;
  logic              ifu_done_o;
  logic              lsu_rd_done_o;
  logic              lsu_wr_done_o;
  logic [DATA_W-1:0] ifu_rdata_o;
  logic [DATA_W-1:0] lsu_rdata_o;
  logic              ar_valid_o;
  logic              ar_ready;
  mbus_ar_t          ar_o;
  logic              r_valid;
  logic              r_ready_o;
  mbus_r_t           r_beat;
  logic              aw_valid_o;
  logic              aw_ready;
  mbus_aw_t          aw_o;
  logic              w_valid_o;
  logic              w_ready;
  mbus_w_t           w_o;
  logic              b_valid;
  logic              b_ready_o;
  mbus_b_t           b_beat;
  logic [7:0]        char_o;
  logic              char_valid_o;
  logic [1:0]        resp_delay;
  mbus_ar_t          ar_seen;
  mbus_aw_t          aw_seen;
  mbus_w_t           w_seen;
  int unsigned       w_count;
  int unsigned       hs_count;
  int unsigned       cycle_cnt;
  logic [31:0]       lfsr;
  logic [7:0]        model_mem [0:4095];
  logic [7:0]        serial_q [$];

  mem_subsys_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .ifu_valid_i    (ifu_valid),
    .ifu_req_i      (ifu_req),
    .lsu_rd_valid_i (lsu_rd_valid),
    .lsu_rd_req_i   (lsu_rd_req),
    .lsu_wr_valid_i (lsu_wr_valid),
    .lsu_wr_req_i   (lsu_wr_req),
    .ifu_done_o     (ifu_done_o),
    .lsu_rd_done_o  (lsu_rd_done_o),
    .lsu_wr_done_o  (lsu_wr_done_o),
    .ifu_rdata_o    (ifu_rdata_o),
    .lsu_rdata_o    (lsu_rdata_o),
    .ar_valid_o     (ar_valid_o),
    .ar_ready_i     (ar_ready),
    .ar_o           (ar_o),
    .r_valid_i      (r_valid),
    .r_ready_o      (r_ready_o),
    .r_i            (r_beat),
    .aw_valid_o     (aw_valid_o),
    .aw_ready_i     (aw_ready),
    .aw_o           (aw_o),
    .w_valid_o      (w_valid_o),
    .w_ready_i      (w_ready),
    .w_o            (w_o),
    .b_valid_i      (b_valid),
    .b_ready_o      (b_ready_o),
    .b_i            (b_beat),
    .char_o         (char_o),
    .char_valid_o   (char_valid_o)
  );

  axi_mem_responder mem0 (
    .clk        (clk),
    .rst        (rst),
    .delay_i    (resp_delay),
    .ar_valid_i (ar_valid_o),
    .ar_ready_o (ar_ready),
    .ar_i       (ar_o),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready_o),
    .r_o        (r_beat),
    .aw_valid_i (aw_valid_o),
    .aw_ready_o (aw_ready),
    .aw_i       (aw_o),
    .w_valid_i  (w_valid_o),
    .w_ready_o  (w_ready),
    .w_i        (w_o),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready_o),
    .b_o        (b_beat),
    .ar_seen_o  (ar_seen),
    .aw_seen_o  (aw_seen),
    .w_seen_o   (w_seen),
    .w_count_o  (w_count),
    .hs_count_o (hs_count)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // galois form, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    rand_bits = val;
  endfunction

  // new responder delay every cycle, away from the drive edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      resp_delay = 2'(rand_bits(2));
    end
  end

  function automatic logic [7:0] fill_byte(input int a);
    fill_byte = 8'(a * 7) ^ 8'(a >> 4) ^ 8'h5a;
  endfunction

  function automatic int rand_nbytes();
    logic [1:0] code;
    code        = 2'(rand_bits(2));
    rand_nbytes = (code == 2'd3) ? 4 : (1 << code);
  endfunction

  // log2 of the access width
  function automatic size_t size_code(input int nbytes);
    size_code = (nbytes == 4) ? SIZE_WORD : ((nbytes == 2) ? SIZE_HALF : SIZE_BYTE);
  endfunction

  // word inside the memory window, offset legal for the size
  function automatic logic [ADDR_W-1:0] rand_addr(input int nbytes);
    logic [ADDR_W-1:0] addr;
    addr       = MEM_BASE | (rand_bits(10) << 2);
    addr[1:0]  = 2'(rand_bits(2) % (5 - nbytes));
    rand_addr  = addr;
  endfunction

  // zero-extended bytes starting at addr
  function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr,
                                                   input int nbytes);
    logic [DATA_W-1:0] val;
    val = '0;
    for (int k = 0; k < nbytes; k++)
    begin
      val[8*k +: 8] = model_mem[addr[11:0] + k];
    end
    model_read = val;
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      fail_stop($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_rdata(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    if (got !== exp)
    begin
      fail_stop($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_char(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      fail_stop($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_ar(input string name, input mbus_ar_t got, input mbus_ar_t exp);
    if (got !== exp)
    begin
      fail_stop($sformatf("error %s got addr %h size %h expected addr %h size %h",
                          name, got.addr, got.size, exp.addr, exp.size));
    end
  endtask

  task automatic check_aw(input string name, input mbus_aw_t got, input mbus_aw_t exp);
    if (got !== exp)
    begin
      fail_stop($sformatf("error %s got addr %h size %h expected addr %h size %h",
                          name, got.addr, got.size, exp.addr, exp.size));
    end
  endtask

  task automatic check_w(input string name, input mbus_w_t got, input mbus_w_t exp);
    if (got !== exp)
    begin
      fail_stop($sformatf("error %s got data %h strb %h last %h expected data %h strb %h last %h",
                          name, got.data, got.strb, got.last, exp.data, exp.strb, exp.last));
    end
  endtask

  // everything quiet right after reset
  task automatic check_reset_state();
    check_bit("ifu_done_o", ifu_done_o, 1'b0);
    check_bit("lsu_rd_done_o", lsu_rd_done_o, 1'b0);
    check_bit("lsu_wr_done_o", lsu_wr_done_o, 1'b0);
    check_bit("ar_valid_o", ar_valid_o, 1'b0);
    check_bit("r_ready_o", r_ready_o, 1'b0);
    check_bit("aw_valid_o", aw_valid_o, 1'b0);
    check_bit("w_valid_o", w_valid_o, 1'b0);
    check_bit("b_ready_o", b_ready_o, 1'b0);
    check_bit("char_valid_o", char_valid_o, 1'b0);
  endtask

  task automatic do_fetch(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] exp;
    mbus_ar_t          exp_ar;
    exp         = model_read(addr, 4);
    exp_ar.addr = addr;
    exp_ar.size = SIZE_WORD;
    @(posedge clk);
    #1;
    ifu_valid    = 1'b1;
    ifu_req.addr = addr;
    ifu_req.strb = 4'hf;
    do
    begin
      @(posedge clk);
      #1;
    end
    while (!ifu_done_o);
    check_rdata("ifu_rdata_o", ifu_rdata_o, exp);
    check_ar("ar_o", ar_seen, exp_ar);
    ifu_valid = 1'b0;
  endtask

  task automatic lsu_load(input logic [ADDR_W-1:0] addr, input logic [3:0] strb,
                          output logic [DATA_W-1:0] got, output int unsigned at);
    @(posedge clk);
    #1;
    lsu_rd_valid    = 1'b1;
    lsu_rd_req.addr = addr;
    lsu_rd_req.strb = strb;
    do
    begin
      @(posedge clk);
      #1;
    end
    while (!lsu_rd_done_o);
    got          = lsu_rdata_o;
    at           = cycle_cnt;
    lsu_rd_valid = 1'b0;
  endtask

  task automatic check_load(input logic [ADDR_W-1:0] addr, input int nbytes);
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] got;
    int unsigned       at;
    mbus_ar_t          exp_ar;
    exp         = model_read(addr, nbytes);
    exp_ar.addr = addr;
    exp_ar.size = size_code(nbytes);
    lsu_load(addr, 4'((1 << nbytes) - 1), got, at);
    check_rdata("lsu_rdata_o", got, exp);
    check_ar("ar_o", ar_seen, exp_ar);
  endtask

  task automatic lsu_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input int nbytes);
    logic [3:0]        strb;
    logic [3:0]        lanes;
    logic [1:0]        off;
    logic [DATA_W-1:0] placed;
    logic              is_serial;
    int unsigned       w_before;
    mbus_aw_t          exp_aw;
    mbus_w_t           exp_w;
    strb      = 4'((1 << nbytes) - 1);
    off       = addr[1:0];
    lanes     = 4'(strb << off);
    placed    = data << (8 * off);
    is_serial = (addr == SERIAL_ADDR);
    w_before  = w_count;
    exp_aw.addr = addr;
    exp_aw.size = size_code(nbytes);
    exp_w.data = {placed, placed};
    exp_w.strb = addr[2] ? {lanes, 4'h0} : {4'h0, lanes};
    exp_w.last = 1'b1;
    if (is_serial)
    begin
      serial_q.push_back(8'(data >> (8 * off)));
    end
    @(posedge clk);
    #1;
    lsu_wr_valid    = 1'b1;
    lsu_wr_req.addr = addr;
    lsu_wr_req.data = data;
    lsu_wr_req.strb = strb;
    do
    begin
      @(posedge clk);
      #1;
      if (is_serial && aw_valid_o)
      begin
        fail_stop("aw_valid_o went high during a store to the serial port");
      end
    end
    while (!lsu_wr_done_o);
    lsu_wr_valid = 1'b0;
    if (is_serial)
    begin
      if (!char_valid_o)
      begin
        fail_stop("char_valid_o was low in the done cycle of a serial store");
      end
      check_char("char_o", char_o, serial_q.pop_front());
    end
    else
    begin
      if (w_count != w_before + 1)
      begin
        fail_stop("store finished without exactly one w handshake");
      end
      check_aw("aw_o", aw_seen, exp_aw);
      check_w("w_o", w_seen, exp_w);
      for (int k = 0; k < nbytes; k++)
      begin
        model_mem[addr[11:0] + k] = data[8*k +: 8];
      end
    end
  endtask

  // both raised in one cycle, the load has to finish first
  task automatic fetch_load_race(input logic [ADDR_W-1:0] faddr,
                                 input logic [ADDR_W-1:0] laddr, input int nbytes);
    logic [DATA_W-1:0] fexp;
    logic [DATA_W-1:0] lexp;
    mbus_ar_t          far;
    mbus_ar_t          lar;
    logic              fdone;
    logic              ldone;
    fexp     = model_read(faddr, 4);
    lexp     = model_read(laddr, nbytes);
    far.addr = faddr;
    far.size = SIZE_WORD;
    lar.addr = laddr;
    lar.size = size_code(nbytes);
    fdone    = 1'b0;
    ldone    = 1'b0;
    @(posedge clk);
    #1;
    ifu_valid       = 1'b1;
    ifu_req.addr    = faddr;
    ifu_req.strb    = 4'hf;
    lsu_rd_valid    = 1'b1;
    lsu_rd_req.addr = laddr;
    lsu_rd_req.strb = 4'((1 << nbytes) - 1);
    while (!(fdone && ldone))
    begin
      @(posedge clk);
      #1;
      if (lsu_rd_done_o)
      begin
        check_rdata("lsu_rdata_o", lsu_rdata_o, lexp);
        check_ar("ar_o", ar_seen, lar);
        lsu_rd_valid = 1'b0;
        ldone        = 1'b1;
      end
      if (ifu_done_o)
      begin
        if (!ldone)
        begin
          fail_stop("fetch finished before the load raised in the same cycle");
        end
        check_rdata("ifu_rdata_o", ifu_rdata_o, fexp);
        check_ar("ar_o", ar_seen, far);
        ifu_valid = 1'b0;
        fdone     = 1'b1;
      end
    end
  endtask

  task automatic mtime_reads();
    logic [DATA_W-1:0] t1;
    logic [DATA_W-1:0] t2;
    logic [DATA_W-1:0] hi;
    int unsigned       c1;
    int unsigned       c2;
    int unsigned       c3;
    int unsigned       hs_before;
    hs_before = hs_count;
    lsu_load(MTIME_LO_ADDR, 4'hf, t1, c1);
    lsu_load(MTIME_LO_ADDR, 4'hf, t2, c2);
    lsu_load(MTIME_HI_ADDR, 4'hf, hi, c3);
    if (hs_count != hs_before)
    begin
      fail_stop("an mtime read caused a master bus handshake");
    end
    if (t2 <= t1)
    begin
      fail_stop($sformatf("error lsu_rdata_o mtime second read %h not above first %h", t2, t1));
    end
    if (t2 - t1 > c2 - c1)
    begin
      fail_stop($sformatf("error lsu_rdata_o mtime step %h exceeds %h cycles", t2 - t1, c2 - c1));
    end
    // short run, upper word still zero
    check_rdata("lsu_rdata_o", hi, '0);
  endtask

  initial
  begin : watchdog
    repeat (5 + N_OPS * 40) @(posedge clk);
    fail_stop("timeout, the test sequence did not finish in time");
  end

  initial
  begin : main
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] beat;
    int                nbytes;
    lfsr         = 32'h7357;
    rst          = 1'b1;
    cycle_cnt    = 0;
    resp_delay   = 2'd0;
    ifu_valid    = 1'b0;
    ifu_req      = '0;
    lsu_rd_valid = 1'b0;
    lsu_rd_req   = '0;
    lsu_wr_valid = 1'b0;
    lsu_wr_req   = '0;
    for (int a = 0; a < 4096; a++)
    begin
      model_mem[a] = fill_byte(a);
      mem0.mem[a]  = fill_byte(a);
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    check_reset_state();

    for (int i = 0; i < N_FETCH; i++)
    begin
      do_fetch(rand_addr(4));
    end
    // every size at every legal offset
    for (int n = 1; n <= 4; n = n * 2)
    begin
      for (int off = 0; off <= 4 - n; off++)
      begin
        check_load((MEM_BASE | (rand_bits(10) << 2)) + off, n);
      end
    end
    for (int i = 0; i < N_LOAD; i++)
    begin
      nbytes = rand_nbytes();
      check_load(rand_addr(nbytes), nbytes);
    end
    for (int i = 0; i < N_RACE; i++)
    begin
      nbytes = rand_nbytes();
      fetch_load_race(rand_addr(4), rand_addr(nbytes), nbytes);
    end
    // store, then read back the whole beat
    for (int i = 0; i < N_STORE; i++)
    begin
      nbytes = rand_nbytes();
      addr   = rand_addr(nbytes);
      beat   = {addr[ADDR_W-1:3], 3'b000};
      lsu_store(addr, rand_bits(32), nbytes);
      check_load(beat, 4);
      check_load(beat + 4, 4);
    end
    mtime_reads();
    for (int i = 0; i < N_SERIAL; i++)
    begin
      lsu_store(SERIAL_ADDR, rand_bits(32), 1);
    end

    repeat (4) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
common/bus_pkg.sv
bus_arbiter/lane_align.sv
bus_arbiter/bus_arbiter.sv
source/clint.sv
source/serial_port.sv
source/mem_subsys_top.sv
dv/axi_mem_responder.sv
dv/tb_mem_subsys.sv
